/* design/gb_io_pkg.sv */
`default_nettype none

package gb_io_pkg;

	// --------------------
	// widths with a meaning
	typedef logic [15:0] addr_t;      // cpu address
	typedef logic [7:0]  byte_t;      // data byte
	typedef logic [4:0]  irq_bits_t;  // bit 0 vblank .. bit 4 joypad
	typedef logic [2:0]  wram_bank_t; // svbk bank number
	typedef logic [14:0] wram_addr_t; // physical wram address, 8 banks of 4k
	typedef logic [6:0]  hram_addr_t; // zero page offset

	// --------------------
	// decoded cpu cycle, strobes already active high
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  rd;
		logic  wr;
		logic  ack; // iorq and m1 together
	} cpu_req_t;

	// one-hot target of the current cycle
	typedef struct packed {
		logic joy;
		logic sb;
		logic sc;
		logic if_reg;
		logic ie;
		logic wram_bank;
		logic wram;
		logic hram;
		logic unmapped;
		logic ack_vec;
	} io_sel_t;

	// --------------------
	// register map
	localparam addr_t ADDR_JOY  = 16'hFF00; // P1
	localparam addr_t ADDR_SB   = 16'hFF01; // serial data
	localparam addr_t ADDR_SC   = 16'hFF02; // serial control
	localparam addr_t ADDR_IF   = 16'hFF0F;
	localparam addr_t ADDR_SVBK = 16'hFF70; // colour mode only
	localparam addr_t ADDR_IE   = 16'hFFFF;

	localparam byte_t IRQ_VECTOR_BASE = 8'h40; // vblank, then +8 per source
	localparam byte_t IRQ_VECTOR_NONE = 8'h55; // ack with nothing pending
	localparam byte_t OPEN_BUS        = 8'hFF;

endpackage

`default_nettype wire

/* design/gb_bus_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_bus_decode
	import gb_io_pkg::*;
(
	input  wire        clk_cpu,
	input  wire        reset_r,
	input  wire addr_t cpu_addr,
	input  wire byte_t cpu_do,
	input  wire        cpu_rd_n,
	input  wire        cpu_wr_n,
	input  wire        cpu_iorq_n,
	input  wire        cpu_m1_n,
	input  wire        is_gbc,
	output cpu_req_t   req,
	output io_sel_t    sel
);

	logic gbc_mode; // mode input retimed onto clk_cpu

	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			gbc_mode <= 1'b0;
		end else begin
			gbc_mode <= is_gbc;
		end
	end

	// --------------------
	// strobes, all active high from here on
	always_comb begin
		req.addr  = cpu_addr;
		req.wdata = cpu_do;
		req.rd    = ~cpu_rd_n;
		req.wr    = ~cpu_wr_n;
		req.ack   = ~cpu_iorq_n & ~cpu_m1_n; // irq acknowledge cycle
	end

	// --------------------
	// address decode, exactly one select set
	always_comb begin
		sel = '0;
		if (req.ack)
			sel.ack_vec = 1'b1; // address is don't care here
		else if (cpu_addr == ADDR_JOY)
			sel.joy = 1'b1;
		else if (cpu_addr == ADDR_SB)
			sel.sb = 1'b1;
		else if (cpu_addr == ADDR_SC)
			sel.sc = 1'b1;
		else if (cpu_addr == ADDR_IF)
			sel.if_reg = 1'b1;
		else if (cpu_addr == ADDR_IE)
			sel.ie = 1'b1;
		else if (cpu_addr == ADDR_SVBK) begin
			sel.wram_bank = gbc_mode;  // svbk only exists on colour hw
			sel.unmapped  = ~gbc_mode;
		end else if (cpu_addr[15:14] == 2'b11 && !(&cpu_addr[13:9]))
			sel.wram = 1'b1; // c000-fdff incl. echo
		else if (cpu_addr[15:7] == 9'h1FF)
			sel.hram = 1'b1; // ff80-fffe, ffff caught above
		else
			sel.unmapped = 1'b1;
	end

endmodule

`default_nettype wire

/* design/gb_irq_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_irq_ctrl
	import gb_io_pkg::*;
(
	input  wire           clk_cpu,
	input  wire           reset_r,
	input  wire cpu_req_t req,
	input  wire io_sel_t  sel,
	input  wire           vblank_irq,
	input  wire           lcd_irq,
	input  wire           timer_irq,
	input  wire           serial_irq,
	input  wire           joy_irq,
	output irq_bits_t     if_reg,
	output irq_bits_t     ie,
	output byte_t         vector,
	output logic          irq_n
);

	localparam int NUM_IRQ = $bits(irq_bits_t);

	irq_bits_t src;      // raw event lines, priority order
	irq_bits_t src_d;    // previous cycle, for edge detect
	irq_bits_t pend;     // flagged and enabled
	irq_bits_t ack_mask; // highest priority pending bit
	logic      ack_d;
	logic      ack_end;

	assign src     = {joy_irq, serial_irq, timer_irq, lcd_irq, vblank_irq};
	assign pend    = if_reg & ie;
	assign ack_end = ack_d & ~req.ack; // clear once the ack cycle is over
	assign irq_n   = ~|pend;

	// --------------------
	// priority pick, bit 0 wins
	always_comb begin
		ack_mask = '0;
		vector   = IRQ_VECTOR_NONE;
		for (int i = NUM_IRQ - 1; i >= 0; i--) begin
			if (pend[i]) begin
				ack_mask = irq_bits_t'(1) << i;
				vector   = IRQ_VECTOR_BASE + byte_t'(8 * i); // 40, 48, 50, 58, 60
			end
		end
	end

	// --------------------
	// flag and enable registers
	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			if_reg <= '0;
			ie     <= '0;
			src_d  <= '0;
			ack_d  <= 1'b0;
		end else begin
			src_d <= src;
			ack_d <= req.ack;

			// set on rising edge of each source, drop the acked one
			if_reg <= (if_reg | (src & ~src_d)) & ~(ack_end ? ack_mask : '0);

			// cpu writes win over events in the same cycle
			if (req.wr && sel.if_reg)
				if_reg <= req.wdata[NUM_IRQ-1:0];
			if (req.wr && sel.ie)
				ie <= req.wdata[NUM_IRQ-1:0];
		end
	end

endmodule

`default_nettype wire

/* design/gb_joypad.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_joypad
	import gb_io_pkg::*;
(
	input  wire           clk_cpu,
	input  wire           reset_r,
	input  wire cpu_req_t req,
	input  wire io_sel_t  sel,
	input  wire [3:0]     joy_din,
	output logic [1:0]    joy_p54,
	output byte_t         joy_rdata,
	output logic          joy_irq
);

	logic [3:0] joy_s1; // first sync stage
	logic [3:0] joy_s2; // second sync stage, older

	// P1 readback, bits 7:6 float high
	assign joy_rdata = {2'b11, joy_p54, joy_din};

	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			joy_p54 <= 2'b11; // no row selected
			joy_s1  <= '1;    // lines idle high, no edge out of reset
			joy_s2  <= '1;
			joy_irq <= 1'b0;
		end else begin
			if (req.wr && sel.joy)
				joy_p54 <= req.wdata[5:4];
			joy_s1  <= joy_din;
			joy_s2  <= joy_s1;
			joy_irq <= |(joy_s2 & ~joy_s1); // any line 1 -> 0
		end
	end

endmodule

`default_nettype wire

/* design/gb_serial_unlinked.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_serial_unlinked
	import gb_io_pkg::*;
#(
	parameter int SERIAL_DIV_BITS = 9 // 512 cycles per bit
) (
	input  wire           clk_cpu,
	input  wire           reset_r,
	input  wire cpu_req_t req,
	input  wire io_sel_t  sel,
	output byte_t         sc_rdata,
	output byte_t         sb_rdata,
	output logic          serial_irq
);

	logic                       sc_start;   // SC bit 7, transfer running
	logic                       sc_int_clk; // SC bit 0, internal clock
	logic [SERIAL_DIV_BITS-1:0] div_q;      // bit period divider
	logic [3:0]                 bit_cnt;    // bits left
	logic                       sc_wr;

	assign sc_wr    = req.wr && sel.sc;
	assign sc_rdata = {sc_start, 6'b111111, sc_int_clk};
	assign sb_rdata = OPEN_BUS; // nothing on the far end, ones shift in

	// --------------------
	// transfer engine
	always_ff @(posedge clk_cpu) begin
		serial_irq <= 1'b0; // single cycle pulse
		if (reset_r) begin
			sc_start   <= 1'b0;
			sc_int_clk <= 1'b0;
			div_q      <= '0;
			bit_cnt    <= '0;
		end else if (sc_wr) begin
			sc_start   <= req.wdata[7];
			sc_int_clk <= req.wdata[0];
			if (req.wdata[7]) begin // kick off a new byte
				div_q   <= '1;
				bit_cnt <= 4'd8;
			end
		end else if (sc_start && sc_int_clk) begin
			div_q <= div_q - SERIAL_DIV_BITS'(1);
			if (div_q == '0 && bit_cnt != 4'd0)
				bit_cnt <= bit_cnt - 4'd1; // one bit period done
			if (bit_cnt == 4'd0) begin
				serial_irq <= 1'b1;
				sc_start   <= 1'b0; // transfer complete
			end
		end
		// external clock selected: waits forever, no partner
	end

endmodule

`default_nettype wire

/* design/gb_work_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_work_ram
	import gb_io_pkg::*;
(
	input  wire           clk_cpu,
	input  wire           reset_r,
	input  wire           is_gbc,
	input  wire cpu_req_t req,
	input  wire io_sel_t  sel,
	output byte_t         wram_rdata,
	output byte_t         hram_rdata,
	output wram_bank_t    wram_bank
);

	localparam int WRAM_BYTES = 2 ** $bits(wram_addr_t); // 32k, 8 banks
	localparam int HRAM_BYTES = 127;                     // ff80-fffe

	byte_t      wram_mem [WRAM_BYTES];
	byte_t      hram_mem [HRAM_BYTES];

	wram_bank_t eff_bank;  // bank actually used for d000-dfff
	wram_addr_t wram_addr;
	hram_addr_t hram_addr;
	logic       bank_wr;

	// --------------------
	// SVBK bank register
	assign bank_wr = req.wr && sel.wram_bank && is_gbc;

	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			wram_bank <= wram_bank_t'(1);
		end else if (bank_wr) begin
			if (req.wdata[2:0] == 3'd0)
				wram_bank <= wram_bank_t'(1); // bank 0 not selectable here
			else
				wram_bank <= req.wdata[2:0];
		end
	end

	// monochrome always sees bank 1 in the upper half
	assign eff_bank = is_gbc ? wram_bank : wram_bank_t'(1);

	// --------------------
	// address mapping
	// bit 12 low  -> fixed bank 0
	// bit 12 high -> switchable bank
	// bit 13 ignored, so e000-fdff echoes c000-ddff
	always_comb begin
		if (req.addr[12])
			wram_addr = {eff_bank, req.addr[11:0]};
		else
			wram_addr = {3'd0, req.addr[11:0]};
	end

	assign hram_addr = req.addr[6:0];

	// --------------------
	// work ram, sync read
	always_ff @(posedge clk_cpu) begin
		if (sel.wram) begin
			if (req.wr)
				wram_mem[wram_addr] <= req.wdata;
			wram_rdata <= wram_mem[wram_addr]; // old data on a write cycle
		end
	end

	// zero page ram, sync read
	always_ff @(posedge clk_cpu) begin
		if (sel.hram) begin
			if (req.wr)
				hram_mem[hram_addr] <= req.wdata;
			hram_rdata <= hram_mem[hram_addr];
		end
	end

endmodule

`default_nettype wire

/* design/gb_read_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_read_mux
	import gb_io_pkg::*;
(
	input  wire cpu_req_t   req,
	input  wire io_sel_t    sel,
	input  wire             is_gbc,
	input  wire irq_bits_t  if_reg,
	input  wire irq_bits_t  ie,
	input  wire byte_t      vector,
	input  wire byte_t      joy_rdata,
	input  wire byte_t      sc_rdata,
	input  wire byte_t      sb_rdata,
	input  wire byte_t      wram_rdata,
	input  wire byte_t      hram_rdata,
	input  wire wram_bank_t wram_bank,
	output byte_t           cpu_di
);

	// --------------------
	// read data select
	always_comb begin
		cpu_di = OPEN_BUS;
		if (sel.ack_vec)
			cpu_di = vector; // rst address for the cpu
		else if (!req.rd)
			cpu_di = OPEN_BUS; // idle bus floats high
		else if (sel.if_reg)
			cpu_di = {3'b111, if_reg};
		else if (sel.ie)
			cpu_di = {3'b111, ie};
		else if (sel.wram_bank && is_gbc)
			cpu_di = {5'b11111, wram_bank};
		else if (sel.joy)
			cpu_di = joy_rdata;
		else if (sel.sb)
			cpu_di = sb_rdata;
		else if (sel.sc)
			cpu_di = sc_rdata;
		else if (sel.wram)
			cpu_di = wram_rdata; // one cycle behind the address
		else if (sel.hram)
			cpu_di = hram_rdata; // same
		else if (sel.unmapped)
			cpu_di = OPEN_BUS;
	end

endmodule

`default_nettype wire

/* design/gb_io_top.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_io_top
	import gb_io_pkg::*;
#(
	parameter int SERIAL_DIV_BITS = 9
) (
	input  wire        clk_cpu,
	input  wire        reset_r,
	input  wire        is_gbc,
	input  wire addr_t cpu_addr,
	input  wire byte_t cpu_do,
	input  wire        cpu_rd_n,
	input  wire        cpu_wr_n,
	input  wire        cpu_iorq_n,
	input  wire        cpu_m1_n,
	input  wire        vblank_irq,
	input  wire        lcd_irq,
	input  wire        timer_irq,
	input  wire [3:0]  joy_din,
	output byte_t      cpu_di,
	output logic       irq_n,
	output logic [1:0] joy_p54
);

	cpu_req_t   req;
	io_sel_t    sel;
	irq_bits_t  if_reg, ie;
	byte_t      vector;
	byte_t      joy_rdata, sc_rdata, sb_rdata;
	byte_t      wram_rdata, hram_rdata;
	wram_bank_t wram_bank;
	logic       serial_irq, joy_irq; // event pulses into the irq block

	// --------------------
	gb_bus_decode u_decode (
		.clk_cpu, .reset_r, .cpu_addr, .cpu_do, .cpu_rd_n, .cpu_wr_n,
		.cpu_iorq_n, .cpu_m1_n, .is_gbc, .req, .sel
	);

	gb_irq_ctrl u_irq (
		.clk_cpu, .reset_r, .req, .sel, .vblank_irq, .lcd_irq, .timer_irq,
		.serial_irq, .joy_irq, .if_reg, .ie, .vector, .irq_n
	);

	gb_joypad u_joy (
		.clk_cpu, .reset_r, .req, .sel, .joy_din, .joy_p54, .joy_rdata, .joy_irq
	);

	gb_serial_unlinked #(
		.SERIAL_DIV_BITS(SERIAL_DIV_BITS)
	) u_serial (
		.clk_cpu, .reset_r, .req, .sel, .sc_rdata, .sb_rdata, .serial_irq
	);

	gb_work_ram u_ram (
		.clk_cpu, .reset_r, .is_gbc, .req, .sel, .wram_rdata, .hram_rdata, .wram_bank
	);

	// --------------------
	gb_read_mux u_rmux (
		.req, .sel, .is_gbc, .if_reg, .ie, .vector, .joy_rdata, .sc_rdata,
		.sb_rdata, .wram_rdata, .hram_rdata, .wram_bank, .cpu_di
	);

endmodule

`default_nettype wire

/* bench/gb_io_tasks.svh */
`ifndef GB_IO_TASKS_SVH
`define GB_IO_TASKS_SVH

	// --------------------
	// cpu bus cycles
	task automatic release_bus();
		cpu_rd_n   = 1'b1;
		cpu_wr_n   = 1'b1;
		cpu_iorq_n = 1'b1;
		cpu_m1_n   = 1'b1;
	endtask

	task automatic bus_write(input addr_t addr, input byte_t data);
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		cpu_addr = addr;
		cpu_do   = data;
		cpu_wr_n = 1'b0;
		@(posedge clk_cpu); // target takes the byte here
		#DRIVE_DELAY;
		release_bus();
	endtask

	// address held over two edges, covers the sync ram latency
	task automatic bus_read(input addr_t addr, output byte_t data);
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		cpu_addr = addr;
		cpu_rd_n = 1'b0;
		repeat (2) @(posedge clk_cpu);
		#DRIVE_DELAY;
		data = cpu_di;
		release_bus();
	endtask

	task automatic read_expect(input addr_t addr, input byte_t exp, input string what);
		byte_t d;
		bus_read(addr, d);
		check_byte($sformatf("%s (%04h)", what, addr), d, exp);
	endtask

	task automatic ack_cycle(output byte_t vec);
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		cpu_iorq_n = 1'b0;
		cpu_m1_n   = 1'b0;
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		vec = cpu_di; // vector while the ack is still low
		release_bus();
		@(posedge clk_cpu); // flag clears on this edge
		#DRIVE_DELAY;
	endtask

	// one cycle high on a video or timer line, 0 vblank 1 lcd 2 timer
	task automatic pulse_source(input int src);
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		vblank_irq = (src == 0);
		lcd_irq    = (src == 1);
		timer_irq  = (src == 2);
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
	endtask

	task automatic wait_if_bit(input int bit_idx, input string what);
		byte_t d;
		int    polls;
		bus_read(ADDR_IF, d);
		for (polls = 0; polls < POLL_LIMIT && !d[bit_idx]; polls++)
			bus_read(ADDR_IF, d);
		if (!d[bit_idx])
			stop_on_failure($sformatf("timeout: IF bit %0d never set after %s", bit_idx, what));
	endtask

	// --------------------
	// directed tests
	task automatic test_reset_values();
		check_level("irq_n after reset", irq_n, 1'b1);
		check_p54("joy_p54 after reset", joy_p54, 2'b11);
		read_expect(ADDR_IF, 8'hE0, "IF after reset");
		read_expect(ADDR_IE, 8'hE0, "IE after reset");
		read_expect(ADDR_SVBK, 8'hF9, "SVBK after reset"); // bank 1
		read_expect(16'hFF03, 8'hFF, "unmapped read");
	endtask

	task automatic test_ram_readback();
		byte_t model [addr_t]; // expected wram content by address
		byte_t zp [127];
		addr_t a;
		byte_t hi, lo, d;
		for (int i = 0; i < 24; i++) begin
			hi = next_rand_byte();
			lo = next_rand_byte();
			a  = 16'hC000 + ({hi, lo} % 16'h1E00); // c000-ddff only
			d  = next_rand_byte();
			model[a] = d;
			bus_write(a, d);
		end
		foreach (model[k]) begin
			read_expect(k, model[k], "wram");
			read_expect(k + 16'h2000, model[k], "wram echo"); // e000 mirror
		end
		for (int i = 0; i < 127; i++) begin
			zp[i] = next_rand_byte();
			bus_write(16'hFF80 + addr_t'(i), zp[i]);
		end
		for (int i = 0; i < 127; i++)
			read_expect(16'hFF80 + addr_t'(i), zp[i], "hram");
	endtask

	task automatic test_banking();
		byte_t d3, d5, dm;
		d3 = next_rand_byte();
		d5 = d3 ^ 8'h5A; // never equal to d3
		dm = ~d3;
		bus_write(ADDR_SVBK, 8'h03);
		read_expect(ADDR_SVBK, 8'hFB, "SVBK bank 3");
		bus_write(16'hD000, d3);
		bus_write(ADDR_SVBK, 8'h05);
		read_expect(ADDR_SVBK, 8'hFD, "SVBK bank 5");
		bus_write(16'hD000, d5);
		read_expect(16'hD000, d5, "bank 5");
		bus_write(ADDR_SVBK, 8'h03);
		read_expect(16'hD000, d3, "bank 3");
		bus_write(ADDR_SVBK, 8'h00); // 0 maps to 1
		read_expect(ADDR_SVBK, 8'hF9, "SVBK after 0");
		bus_write(ADDR_SVBK, 8'h05); // bank 5 still selected going into mono
		// monochrome, register hidden
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		is_gbc = 1'b0;
		read_expect(ADDR_SVBK, 8'hFF, "SVBK in mono mode");
		bus_write(ADDR_SVBK, 8'h03); // must be ignored
		bus_write(16'hD000, dm);     // lands in bank 1 whatever SVBK holds
		read_expect(16'hD000, dm, "mono D000");
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		is_gbc = 1'b1;
		read_expect(ADDR_SVBK, 8'hFD, "SVBK after mono write");
		read_expect(16'hD000, d5, "bank 5 untouched by mono");
		bus_write(ADDR_SVBK, 8'h01);
		read_expect(16'hD000, dm, "bank 1 from mono");
	endtask

	task automatic test_interrupts();
		byte_t d;
		bus_write(ADDR_IE, 8'h1F);
		pulse_source(0);
		pulse_source(2);
		read_expect(ADDR_IF, 8'hE5, "IF vblank and timer");
		check_level("irq_n two pending", irq_n, 1'b0);
		ack_cycle(d);
		check_byte("first ack vector", d, 8'h40);
		bus_read(ADDR_IF, d);
		check_irq_bits("IF after first ack", d[4:0], 5'b00100);
		ack_cycle(d);
		check_byte("second ack vector", d, 8'h50);
		check_level("irq_n none pending", irq_n, 1'b1);
		ack_cycle(d);
		check_byte("idle ack vector", d, 8'h55);
	endtask

	task automatic test_joypad();
		bus_write(ADDR_JOY, 8'h20);
		check_p54("joy_p54 after write", joy_p54, 2'b10);
		read_expect(ADDR_JOY, 8'hE0 | {4'h0, joy_din}, "P1 idle");
		bus_write(ADDR_IF, 8'h00);
		@(posedge clk_cpu);
		#DRIVE_DELAY;
		joy_din = 4'hB; // line 2 pressed
		wait_if_bit(4, "joypad line drop");
		read_expect(ADDR_JOY, 8'hEB, "P1 line 2 low");
		joy_din = 4'hF; // release, rising edge stays quiet
	endtask

	task automatic test_serial();
		byte_t d;
		int    polls;
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_SC, 8'h81); // start, internal clock
		read_expect(ADDR_SC, 8'hFF, "SC while shifting");
		d = 8'hFF;
		for (polls = 0; polls < POLL_LIMIT && d[7]; polls++)
			bus_read(ADDR_SC, d);
		if (d[7])
			stop_on_failure("timeout: serial transfer never cleared SC bit 7");
		bus_read(ADDR_IF, d);
		check_irq_bits("IF after transfer", d[4:0], 5'b01000);
		read_expect(ADDR_SC, 8'h7F, "SC after transfer");
		read_expect(ADDR_SB, 8'hFF, "SB with no partner");
	endtask

`endif

/* bench/gb_io_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module gb_io_tb
	import gb_io_pkg::*;
();

	localparam int DRIVE_DELAY = 2;   // ns after the rising edge
	localparam int POLL_LIMIT  = 200; // polls before a wait gives up

	logic        clk_cpu;
	logic        reset_r;
	logic        is_gbc;
	addr_t       cpu_addr;
	byte_t       cpu_do;
	logic        cpu_rd_n, cpu_wr_n, cpu_iorq_n, cpu_m1_n;
	logic        vblank_irq, lcd_irq, timer_irq;
	logic [3:0]  joy_din;  // active low lines
	byte_t       cpu_di;
	logic        irq_n;
	logic [1:0]  joy_p54;
	logic [31:0] lcg_state;

	// short divider so a serial byte takes 8 x 16 cycles
	gb_io_top #(.SERIAL_DIV_BITS(4)) u_dut (.*);

	initial begin
		clk_cpu = 1'b0;
		forever #4 clk_cpu = ~clk_cpu; // 8 ns period
	end

	// --------------------
	// pattern source
	function automatic byte_t next_rand_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16]; // middle bits, low ones cycle fast
	endfunction

	// --------------------
	// failure and compares
	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		if (got !== exp)
			stop_on_failure($sformatf("Error at %0t ns: %s read %02h, expected %02h",
				$time, what, got, exp));
	endtask

	task automatic check_irq_bits(input string what, input irq_bits_t got,
		input irq_bits_t exp);
		if (got !== exp)
			stop_on_failure($sformatf("Error at %0t ns: %s flags %05b, expected %05b",
				$time, what, got, exp));
	endtask

	task automatic check_level(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_on_failure($sformatf("Error at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_p54(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			stop_on_failure($sformatf("Error at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// --------------------
	// test sequence
	initial begin
		lcg_state  = 32'd58;
		reset_r    = 1'b1;
		is_gbc     = 1'b1; // colour mode unless a test says otherwise
		cpu_addr   = '0;
		cpu_do     = '0;
		release_bus();
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		joy_din    = 4'hF; // nothing pressed
		repeat (10) @(posedge clk_cpu);
		#DRIVE_DELAY;
		reset_r = 1'b0;

		test_reset_values();
		test_ram_readback();
		test_banking();
		test_interrupts();
		test_joypad();
		test_serial();

		$display("Simulation PASSED");
		$finish;
	end

	`include "gb_io_tasks.svh"

endmodule

`default_nettype wire

/* sources.f */
+incdir+bench
design/gb_io_pkg.sv
design/gb_bus_decode.sv
design/gb_irq_ctrl.sv
design/gb_joypad.sv
design/gb_serial_unlinked.sv
design/gb_work_ram.sv
design/gb_read_mux.sv
design/gb_io_top.sv
bench/gb_io_tb.sv

/* run_sim.sh */
#!/bin/bash
# build the gb_io testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
	--top-module gb_io_tb -f sources.f -o gb_io_sim

# the simulation exits nonzero on a fatal error, output is still searched
sim_out=$(./obj_dir/gb_io_sim 2>&1) || true
echo "$sim_out"

if grep -qx "Simulation PASSED" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
